// ==== rtl/dma_pkg.sv ====
// shared dma types; register offsets are byte offsets inside the 0x100 register page
package dma_pkg;

    // word count width for the len register and the engine counter
    parameter int len_w = 16;

    // bit positions in ctrl and status
    parameter int ctrl_start = 0;
    parameter int stat_busy  = 0;
    parameter int stat_done  = 1;
    parameter int stat_err   = 2;

    typedef enum logic [2:0] {
        st_idle  = 3'd0,
        st_read  = 3'd1,
        st_write = 3'd2,
        st_next  = 3'd3,
        st_done  = 3'd4
    } dma_state_t;

    typedef enum logic [4:0] {
        reg_ctrl   = 5'h00,
        reg_status = 5'h04,
        reg_src    = 5'h08,
        reg_dst    = 5'h0c,
        reg_len    = 5'h10
    } dma_reg_t;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } axi_resp_t;

endpackage

// ==== rtl/dma_regs.sv ====
`timescale 1ns/1ps
// axi4-lite slave, one write and one read outstanding; needs dwidth >= len_w, mem_words a power of two
module dma_regs
    import dma_pkg::*;
#(
    parameter int dwidth    = 32,
    parameter int awidth    = 32,
    parameter int mem_words = 64,
    localparam int ba_w     = $clog2(mem_words) + $clog2(dwidth / 8)
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [awidth-1:0] awaddr,
    input  logic              awvalid,
    output logic              awready,
    input  logic [dwidth-1:0] wdata,
    input  logic              wvalid,
    output logic              wready,
    output axi_resp_t         bresp,
    output logic              bvalid,
    input  logic              bready,
    input  logic [awidth-1:0] araddr,
    input  logic              arvalid,
    output logic              arready,
    output logic [dwidth-1:0] rdata,
    output axi_resp_t         rresp,
    output logic              rvalid,
    input  logic              rready,
    output logic              start,
    output logic [awidth-1:0] src_addr,
    output logic [awidth-1:0] dst_addr,
    output logic [len_w-1:0]  length,
    input  logic              busy,
    input  logic              done,
    output logic [ba_w-1:0]   host_addr,
    output logic [dwidth-1:0] host_wdata,
    output logic              host_we,
    input  logic [dwidth-1:0] host_rdata
);
    localparam logic [awidth-1:0] win_base = awidth'(32'h100);
    localparam logic [awidth-1:0] win_end  = win_base + awidth'(mem_words * (dwidth / 8));

    logic              aw_full;
    logic [awidth-1:0] aw_addr_q;
    logic              w_full;
    logic [dwidth-1:0] w_data_q;
    logic              aw_hs;
    logic              w_hs;
    logic              ar_hs;
    logic              wr_go;
    logic [awidth-1:0] wr_addr;
    logic [dwidth-1:0] wr_data;
    logic              wr_reg;
    logic              wr_win;
    dma_reg_t          wr_off;
    logic              rd_reg;
    logic              rd_win;
    dma_reg_t          rd_off;
    logic [awidth-1:0] win_wr_off;
    logic [awidth-1:0] win_rd_off;
    logic [dwidth-1:0] rd_value;
    logic              cfg_lock;
    logic              done_st;
    logic              err_st;

    function automatic logic is_reg(input logic [awidth-1:0] addr);
        return addr < win_base && addr[7:5] == 3'b000 &&
               addr[4:0] inside {reg_ctrl, reg_status, reg_src, reg_dst, reg_len};
    endfunction

    function automatic logic is_win(input logic [awidth-1:0] addr);
        return addr >= win_base && addr < win_end;
    endfunction

    // AW and W are latched separately, the write runs once both are in
    assign awready = !aw_full && !bvalid;
    assign wready  = !w_full && !bvalid;
    assign aw_hs   = awvalid && awready;
    assign w_hs    = wvalid && wready;
    assign wr_addr = aw_full ? aw_addr_q : awaddr;
    assign wr_data = w_full ? w_data_q : wdata;
    assign wr_go   = (aw_full || aw_hs) && (w_full || w_hs);
    assign wr_reg  = is_reg(wr_addr);
    assign wr_win  = is_win(wr_addr);
    assign wr_off  = dma_reg_t'(wr_addr[4:0]);

    // host port belongs to the write on a window write cycle
    assign arready = !rvalid && !(wr_go && wr_win);
    assign ar_hs   = arvalid && arready;
    assign rd_reg  = is_reg(araddr);
    assign rd_win  = is_win(araddr);
    assign rd_off  = dma_reg_t'(araddr[4:0]);

    assign win_wr_off = wr_addr - win_base;
    assign win_rd_off = araddr - win_base;
    assign host_we    = wr_go && wr_win;
    assign host_addr  = host_we ? win_wr_off[ba_w-1:0] : win_rd_off[ba_w-1:0];
    assign host_wdata = wr_data;

    assign cfg_lock = busy || start;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aw_full <= 1'b0;
            w_full  <= 1'b0;
            bvalid  <= 1'b0;
        end else if (wr_go) begin
            aw_full <= 1'b0;
            w_full  <= 1'b0;
            bvalid  <= 1'b1;
        end else begin
            if (aw_hs) begin
                aw_full <= 1'b1;
            end
            if (w_hs) begin
                w_full <= 1'b1;
            end
            if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            aw_addr_q <= awaddr;
        end
        if (w_hs) begin
            w_data_q <= wdata;
        end
        if (wr_go) begin
            bresp <= (wr_reg || wr_win) ? resp_okay : resp_slverr;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start    <= 1'b0;
            done_st  <= 1'b0;
            err_st   <= 1'b0;
            src_addr <= '0;
            dst_addr <= '0;
            length   <= '0;
        end else begin
            // engine finished, hand the level back and latch sticky done
            if (start && done) begin
                start   <= 1'b0;
                done_st <= 1'b1;
            end
            if (wr_go && wr_reg) begin
                case (wr_off)
                    reg_ctrl: begin
                        if (wr_data[ctrl_start] && !cfg_lock) begin
                            if (length == '0) begin
                                err_st <= 1'b1;
                            end else begin
                                start   <= 1'b1;
                                done_st <= 1'b0;
                                err_st  <= 1'b0;
                            end
                        end
                    end
                    reg_status: begin
                        if (wr_data[stat_done]) begin
                            done_st <= 1'b0;
                        end
                        if (wr_data[stat_err]) begin
                            err_st <= 1'b0;
                        end
                    end
                    reg_src: begin
                        if (!cfg_lock) begin
                            src_addr <= awidth'(wr_data);
                        end
                    end
                    reg_dst: begin
                        if (!cfg_lock) begin
                            dst_addr <= awidth'(wr_data);
                        end
                    end
                    reg_len: begin
                        if (!cfg_lock) begin
                            length <= wr_data[len_w-1:0];
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    always_comb begin
        rd_value = '0;
        if (rd_win) begin
            rd_value = host_rdata;
        end else if (rd_reg) begin
            case (rd_off)
                reg_ctrl:   rd_value[ctrl_start] = start;
                reg_status: begin
                    // start counts as busy until the engine picks it up
                    rd_value[stat_busy] = busy || start;
                    rd_value[stat_done] = done_st;
                    rd_value[stat_err]  = err_st;
                end
                reg_src:    rd_value = dwidth'(src_addr);
                reg_dst:    rd_value = dwidth'(dst_addr);
                reg_len:    rd_value = dwidth'(length);
                default:    rd_value = '0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
        end else if (ar_hs) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rdata <= rd_value;
            rresp <= (rd_reg || rd_win) ? resp_okay : resp_slverr;
        end
    end

endmodule

// ==== rtl/dma_engine.sv ====
`timescale 1ns/1ps
// word copy engine, one word in flight; a zero length must never be started
module dma_engine
    import dma_pkg::*;
#(
    parameter int dwidth = 32,
    parameter int awidth = 32
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  logic [awidth-1:0] src_addr,
    input  logic [awidth-1:0] dst_addr,
    input  logic [len_w-1:0]  length,
    output logic              busy,
    output logic              done,
    output logic [awidth-1:0] mem_addr,
    output logic [dwidth-1:0] mem_wdata,
    output logic              mem_rd,
    output logic              mem_wr,
    input  logic [dwidth-1:0] mem_rdata,
    input  logic              mem_ready
);
    // byte step per word
    localparam logic [awidth-1:0] step = awidth'(dwidth / 8);

    dma_state_t        state;
    dma_state_t        state_nxt;
    logic [awidth-1:0] cur_src;
    logic [awidth-1:0] cur_dst;
    logic [len_w-1:0]  remain;
    logic [dwidth-1:0] word_buf;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (start) begin
                    state_nxt = st_read;
                end
            end
            st_read: begin
                if (mem_ready) begin
                    state_nxt = st_write;
                end
            end
            st_write: begin
                if (mem_ready) begin
                    state_nxt = st_next;
                end
            end
            st_next: begin
                state_nxt = (remain == len_w'(1)) ? st_done : st_read;
            end
            st_done: begin
                // hold done until the register block drops start
                if (!start) begin
                    state_nxt = st_idle;
                end
            end
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            remain <= '0;
        end else if (state == st_idle && start) begin
            remain <= length;
        end else if (state == st_next) begin
            remain <= remain - len_w'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && start) begin
            cur_src <= src_addr;
            cur_dst <= dst_addr;
        end else if (state == st_next) begin
            cur_src <= cur_src + step;
            cur_dst <= cur_dst + step;
        end
        if (state == st_read && mem_ready) begin
            word_buf <= mem_rdata;
        end
    end

    // request held for the whole state, dropped as ready moves us on
    assign mem_rd    = (state == st_read);
    assign mem_wr    = (state == st_write);
    assign mem_addr  = (state == st_write) ? cur_dst : cur_src;
    assign mem_wdata = word_buf;

    assign busy = state inside {st_read, st_write, st_next};
    assign done = (state == st_done);

endmodule

// ==== rtl/dma_sram.sv ====
`timescale 1ns/1ps
// dual-port word memory, byte addresses with low bits ignored; mem_words a power of two, at least 2
module dma_sram #(
    parameter int dwidth    = 32,
    parameter int mem_words = 64,
    localparam int ba_w     = $clog2(mem_words) + $clog2(dwidth / 8)
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [ba_w-1:0]   host_addr,
    input  logic [dwidth-1:0] host_wdata,
    input  logic              host_we,
    output logic [dwidth-1:0] host_rdata,
    input  logic [ba_w-1:0]   mem_addr,
    input  logic [dwidth-1:0] mem_wdata,
    input  logic              mem_rd,
    input  logic              mem_wr,
    output logic [dwidth-1:0] mem_rdata,
    output logic              mem_ready
);
    localparam int lsb = $clog2(dwidth / 8);

    logic [dwidth-1:0]     mem [mem_words];
    logic [ba_w-lsb-1:0]   host_idx;
    logic [ba_w-lsb-1:0]   mem_idx;

    assign host_idx   = host_addr[ba_w-1:lsb];
    assign mem_idx    = mem_addr[ba_w-1:lsb];
    assign host_rdata = mem[host_idx];

    // one wait state, ready never on two cycles in a row
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_ready <= 1'b0;
        end else begin
            mem_ready <= (mem_rd || mem_wr) && !mem_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (host_we) begin
            mem[host_idx] <= host_wdata;
        end
        // engine write comes last so it wins a same-word collision
        if (mem_wr && mem_ready) begin
            mem[mem_idx] <= mem_wdata;
        end
        if (mem_rd && !mem_ready) begin
            mem_rdata <= mem[mem_idx];
        end
    end

endmodule

// ==== rtl/dma_subsys.sv ====
`timescale 1ns/1ps
// dma subsystem top: register page at 0x000, memory window from 0x100, single AXI4-Lite slave
module dma_subsys
    import dma_pkg::*;
#(
    parameter int dwidth    = 32,
    parameter int awidth    = 32,
    parameter int mem_words = 64
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [awidth-1:0] awaddr,
    input  logic              awvalid,
    output logic              awready,
    input  logic [dwidth-1:0] wdata,
    input  logic              wvalid,
    output logic              wready,
    output axi_resp_t         bresp,
    output logic              bvalid,
    input  logic              bready,
    input  logic [awidth-1:0] araddr,
    input  logic              arvalid,
    output logic              arready,
    output logic [dwidth-1:0] rdata,
    output axi_resp_t         rresp,
    output logic              rvalid,
    input  logic              rready
);
    localparam int ba_w = $clog2(mem_words) + $clog2(dwidth / 8);

    logic              start;
    logic              busy;
    logic              done;
    logic [awidth-1:0] src_addr;
    logic [awidth-1:0] dst_addr;
    logic [len_w-1:0]  length;
    logic [awidth-1:0] mem_addr;
    logic [dwidth-1:0] mem_wdata;
    logic [dwidth-1:0] mem_rdata;
    logic              mem_rd;
    logic              mem_wr;
    logic              mem_ready;
    logic [ba_w-1:0]   host_addr;
    logic [dwidth-1:0] host_wdata;
    logic [dwidth-1:0] host_rdata;
    logic              host_we;

    dma_regs #(
        .dwidth    (dwidth),
        .awidth    (awidth),
        .mem_words (mem_words)
    ) u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .start      (start),
        .src_addr   (src_addr),
        .dst_addr   (dst_addr),
        .length     (length),
        .busy       (busy),
        .done       (done),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_we    (host_we),
        .host_rdata (host_rdata)
    );

    dma_engine #(
        .dwidth (dwidth),
        .awidth (awidth)
    ) u_engine (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .src_addr  (src_addr),
        .dst_addr  (dst_addr),
        .length    (length),
        .busy      (busy),
        .done      (done),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rd    (mem_rd),
        .mem_wr    (mem_wr),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready)
    );

    // memory decodes only the low byte-address bits of the engine address
    dma_sram #(
        .dwidth    (dwidth),
        .mem_words (mem_words)
    ) u_sram (
        .clk        (clk),
        .rst_n      (rst_n),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_we    (host_we),
        .host_rdata (host_rdata),
        .mem_addr   (mem_addr[ba_w-1:0]),
        .mem_wdata  (mem_wdata),
        .mem_rd     (mem_rd),
        .mem_wr     (mem_wr),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready)
    );

endmodule

// ==== test/dma_subsys_tb.sv ====
`timescale 1ns/1ps
// single AXI4-Lite master; expects 32-bit data and 64 memory words, copy ranges never overlap
module dma_subsys_tb
    import dma_pkg::*;
();
    localparam int          timeout = 400;
    localparam logic [31:0] win     = 32'h100;

    typedef struct packed {
        logic [7:0]  src;
        logic [7:0]  dst;
        logic [15:0] len;
        logic        err;
        logic        stall;
    } copy_t;

    logic        clk;
    logic        rst_n;
    logic [31:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic        wvalid;
    logic        wready;
    axi_resp_t   bresp;
    logic        bvalid;
    logic        bready;
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    axi_resp_t   rresp;
    logic        rvalid;
    logic        rready;

    copy_t copies [5];
    int    errors    = 0;
    int    checks    = 0;
    int    tests_run = 0;
    bit    hung      = 1'b0;
    bit    stall     = 1'b0;

    dma_subsys i_dma_subsys (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // destination background, differs for every word index
    function automatic logic [31:0] fill(input int idx);
        return 32'h5a5a_0000 ^ (32'(idx) * 32'h0001_0001);
    endfunction

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (hung) return;
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_resp(input string name, input axi_resp_t got, input axi_resp_t exp);
        if (hung) return;
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t %s got %s expected %s", $time, name, got.name(), exp.name());
        end
    endtask

    task automatic report_hang(input string what);
        errors++;
        hung = 1'b1;
        $display("timeout at %0t while waiting for %s", $time, what);
    endtask

    task automatic take_response(input bit is_write, output axi_resp_t resp,
                                 output logic [31:0] data);
        int n;
        bit seen;
        // stalled tests keep ready low for a few cycles
        if (stall) begin
            repeat ($urandom_range(4, 1)) @(negedge clk);
        end
        if (is_write) bready = 1'b1;
        else rready = 1'b1;
        n = 0;
        #2;
        while (!(is_write ? bvalid : rvalid) && n < timeout) begin
            @(negedge clk);
            #2;
            n++;
        end
        seen = is_write ? bvalid : rvalid;
        resp = is_write ? bresp : rresp;
        data = rdata;
        @(negedge clk);
        bready = 1'b0;
        rready = 1'b0;
        if (!seen) begin
            report_hang(is_write ? "bvalid" : "rvalid");
            return;
        end
        #2;
        if (is_write ? bvalid : rvalid) begin
            errors++;
            $display("a second %s response followed one handshake", is_write ? "write" : "read");
        end
    endtask

    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                             output axi_resp_t resp);
        int          n;
        bit          aw_take;
        bit          w_take;
        logic [31:0] unused;
        resp = resp_slverr;
        if (hung) return;
        @(negedge clk);
        awaddr  = addr;
        awvalid = 1'b1;
        wdata   = data;
        wvalid  = 1'b1;
        n = 0;
        while ((awvalid || wvalid) && n < timeout) begin
            #2;
            aw_take = awvalid && awready;
            w_take  = wvalid && wready;
            @(negedge clk);
            if (aw_take) awvalid = 1'b0;
            if (w_take) wvalid = 1'b0;
            n++;
        end
        if (awvalid || wvalid) begin
            awvalid = 1'b0;
            wvalid  = 1'b0;
            report_hang("awready or wready");
            return;
        end
        take_response(1'b1, resp, unused);
    endtask

    task automatic axi_read(input logic [31:0] addr, output logic [31:0] data,
                            output axi_resp_t resp);
        int n;
        resp = resp_slverr;
        data = '0;
        if (hung) return;
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        n = 0;
        #2;
        while (!arready && n < timeout) begin
            @(negedge clk);
            #2;
            n++;
        end
        if (!arready) begin
            arvalid = 1'b0;
            report_hang("arready");
            return;
        end
        @(negedge clk);
        arvalid = 1'b0;
        take_response(1'b0, resp, data);
    endtask

    task automatic write_ok(input logic [31:0] addr, input logic [31:0] data, input string name);
        axi_resp_t resp;
        axi_write(addr, data, resp);
        check_resp({name, " bresp"}, resp, resp_okay);
    endtask

    task automatic read_expect(input logic [31:0] addr, input logic [31:0] exp, input string name);
        axi_resp_t   resp;
        logic [31:0] data;
        axi_read(addr, data, resp);
        check_resp({name, " rresp"}, resp, resp_okay);
        check_word(name, data, exp);
    endtask

    task automatic run_copy(input int t, input copy_t c);
        logic [31:0] src_data [$];
        logic [31:0] data;
        axi_resp_t   resp;
        int          err_before;
        int          span;
        int          polls;
        bit          saw_busy;
        err_before = errors;
        stall = c.stall;
        span = (c.len == 0) ? 4 : int'(c.len);
        for (int i = 0; i < span; i++) begin
            write_ok(win + 32'((c.dst + i) * 4), fill(c.dst + i), "dst fill");
        end
        for (int i = 0; i < int'(c.len); i++) begin
            src_data.push_back($urandom());
            write_ok(win + 32'((c.src + i) * 4), src_data[i], "src load");
        end
        write_ok(32'(reg_src), 32'(c.src) * 4, "src");
        write_ok(32'(reg_dst), 32'(c.dst) * 4, "dst");
        write_ok(32'(reg_len), 32'(c.len), "len");
        read_expect(32'(reg_src), 32'(c.src) * 4, "src readback");
        read_expect(32'(reg_dst), 32'(c.dst) * 4, "dst readback");
        read_expect(32'(reg_len), 32'(c.len), "len readback");
        write_ok(32'(reg_ctrl), 32'h1, "ctrl start");
        if (c.err) begin
            // empty copy sets err only, busy never shows
            read_expect(32'(reg_status), 32'h4, "status after empty start");
            write_ok(32'(reg_status), 32'h4, "status err clear");
            read_expect(32'(reg_status), 32'h0, "status err cleared");
        end else begin
            polls = 0;
            saw_busy = 1'b0;
            data = '0;
            while (!data[1] && polls < timeout && !hung) begin
                axi_read(32'(reg_status), data, resp);
                saw_busy = saw_busy | data[0];
                polls++;
            end
            if (!data[1] && !hung) report_hang("status done");
            if (c.len >= 16 && !saw_busy && !hung) begin
                errors++;
                $display("status never showed busy during a %0d word copy", c.len);
            end
            repeat (2) read_expect(32'(reg_status), 32'h2, "status done held");
            write_ok(32'(reg_status), 32'h2, "status done clear");
            read_expect(32'(reg_status), 32'h0, "status done cleared");
        end
        for (int i = 0; i < span; i++) begin
            if (c.err) read_expect(win + 32'((c.dst + i) * 4), fill(c.dst + i), "dst word");
            else read_expect(win + 32'((c.dst + i) * 4), src_data[i], "dst word");
        end
        for (int i = 0; i < int'(c.len); i++) begin
            read_expect(win + 32'((c.src + i) * 4), src_data[i], "src word");
        end
        tests_run++;
        $display("test %0d copy %0d words %0d to %0d stall %0d: %s", t, c.len, c.src, c.dst,
                 c.stall, (errors == err_before) ? "ok" : "errors");
    endtask

    task automatic run_decode(input int t);
        // 0x88 and 0x90 alias src and len in their low bits
        logic [31:0] bad [5] = '{32'h14, 32'h88, 32'h90, 32'h200, 32'h1000};
        logic [31:0] src_now;
        logic [31:0] len_now;
        logic [31:0] data;
        axi_resp_t   resp;
        int          err_before;
        err_before = errors;
        stall = 1'b1;
        axi_read(32'(reg_src), src_now, resp);
        axi_read(32'(reg_len), len_now, resp);
        for (int i = 0; i < 5; i++) begin
            axi_write(bad[i], 32'hffff_fff0, resp);
            check_resp("unmapped write bresp", resp, resp_slverr);
            axi_read(bad[i], data, resp);
            check_resp("unmapped read rresp", resp, resp_slverr);
        end
        read_expect(32'(reg_src), src_now, "src after unmapped writes");
        read_expect(32'(reg_len), len_now, "len after unmapped writes");
        tests_run++;
        $display("test %0d decode errors: %s", t, (errors == err_before) ? "ok" : "errors");
    endtask

    initial begin
        void'($urandom(32'h15a0baf7));
        rst_n   = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        // src, dst, len, err expected, stall
        copies[0] = '{8'd0, 8'd16, 16'd4, 1'b0, 1'b0};
        copies[1] = '{8'd4, 8'd40, 16'd20, 1'b0, 1'b0};
        copies[2] = '{8'd8, 8'd24, 16'd0, 1'b1, 1'b0};
        copies[3] = '{8'd32, 8'd2, 16'd7, 1'b0, 1'b1};
        copies[4] = '{8'd50, 8'd10, 16'd12, 1'b0, 1'b1};
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int t = 0; t < 5 && !hung; t++) begin
            run_copy(t + 1, copies[t]);
        end
        if (!hung) run_decode(6);
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== dma_subsys.f ====
rtl/dma_pkg.sv
rtl/dma_regs.sv
rtl/dma_engine.sv
rtl/dma_sram.sv
rtl/dma_subsys.sv
test/dma_subsys_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the dma subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module dma_subsys_tb \
        -f dma_subsys.f --Mdir obj_dir -o dma_sim; then
    echo "verilator build failed"
    exit 1
fi

if ! out=$(./obj_dir/dma_sim); then
    printf '%s\n' "$out"
    echo "simulation exited with an error"
    exit 1
fi

printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "test passed"; then
    exit 0
fi

echo "pass message not found"
exit 1
